//--- Makefile
SRCS := $(shell grep -v '^+' verilog.f) common/bus_config.svh

.PHONY: all run clean

all: obj_dir/Vtb_mem_bus

obj_dir/Vtb_mem_bus: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mem_bus -f verilog.f

run: obj_dir/Vtb_mem_bus
	obj_dir/Vtb_mem_bus | tee /dev/stderr | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

//--- bus_ctrl/bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module bus_ctrl import bus_pkg::*; (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 start,
	input  mem_op_t             op,
	input  wire  [`ADDR_W-1:0]  addr,
	input  wire  [`DATA_W-1:0]  wdata,
	input  wire  [7:0]          front_data,
	input  wire                 empty,
	input  wire                 full,
	input  wire  [`DATA_W-1:0]  bus_in,
	input  wire                 data_ready,
	input  wire                 tbre,
	input  wire                 tsre,
	output logic                finish,
	output logic [`DATA_W-1:0]  rdata,
	output logic                push,
	output logic [7:0]          push_data,
	output logic                pop,
	output wire  [`ADDR_W-1:0]  ram_addr,
	output logic                ram_en_n,
	output logic                ram_oe_n,
	output logic                ram_we_n,
	output logic [`DATA_W-1:0]  bus_out,
	output logic                bus_oe,
	output logic                uart_rdn,
	output logic                uart_wrn
);

	localparam int DIV_W = (`TICK_DIV > 1) ? $clog2(`TICK_DIV) : 1;
	localparam int WAIT_W = $clog2(`TX_WAIT_MAX + 1);

	logic [DIV_W-1:0]  tick_cnt;
	logic              tick;
	bus_state_t        state;
	mem_op_t           op_q;
	logic              req_pend;
	logic [WAIT_W-1:0] wait_cnt;
	logic              wait_over;
	logic              pop_phase;

	// SRAM address comes straight from the held request
	assign ram_addr = addr;

	////////////////////
	// Bus tick
	////////////////////

	assign tick = (tick_cnt == DIV_W'(`TICK_DIV - 1));

	always_ff @(posedge clk) begin
		if (!rst)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign wait_over = (wait_cnt == WAIT_W'(`TX_WAIT_MAX));

	////////////////////
	// Sequencer
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= ST_IDLE;
			req_pend <= 1'b0;
			finish <= 1'b0;
			push <= 1'b0;
			pop <= 1'b0;
			ram_en_n <= 1'b1;
			ram_oe_n <= 1'b1;
			ram_we_n <= 1'b1;
			bus_oe <= 1'b0;
			uart_rdn <= 1'b1;
			uart_wrn <= 1'b1;
			wait_cnt <= '0;
			pop_phase <= 1'b0;
		end else begin
			finish <= 1'b0;
			push <= 1'b0;
			pop <= 1'b0;

			// start may land while a receive is in flight
			if (start) begin
				req_pend <= 1'b1;
				op_q <= op;
			end

			case (state)
				ST_IDLE: begin
					if (tick && data_ready && !full) begin
						uart_rdn <= 1'b0;
						state <= ST_RX1;
					end else if (req_pend) begin
						req_pend <= 1'b0;
						case (op_q)
							OP_RAM_RD: state <= ST_RD1;
							OP_RAM_WR: state <= ST_WR1;
							OP_UART_RD: state <= ST_QPOP;
							OP_UART_WR: state <= ST_TX1;
							OP_UART_STAT: state <= ST_STAT;
							default: finish <= 1'b1;
						endcase
					end
				end

				// UART receive into the queue
				ST_RX1: if (tick) begin
					push_data <= bus_in[7:0];
					push <= 1'b1;
					state <= ST_RX2;
				end
				ST_RX2: if (tick) begin
					uart_rdn <= 1'b1;
					state <= ST_RX3;
				end
				// Recovery tick so data_ready can settle
				ST_RX3: if (tick) state <= ST_IDLE;

				// UART transmit
				ST_TX1: if (tick) begin
					bus_out <= wdata;
					bus_oe <= 1'b1;
					uart_wrn <= 1'b0;
					wait_cnt <= '0;
					state <= ST_TX2;
				end
				ST_TX2: if (tick) begin
					uart_wrn <= 1'b1;
					state <= ST_TX3;
				end
				ST_TX3: if (tick) begin
					bus_oe <= 1'b0;
					if (tbre) begin
						wait_cnt <= '0;
						state <= ST_TX4;
					end else if (wait_over) begin
						state <= ST_TX1;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				ST_TX4: if (tick) begin
					if (tsre) begin
						finish <= 1'b1;
						state <= ST_IDLE;
					end else if (wait_over) begin
						state <= ST_TX1;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end

				// SRAM read
				ST_RD1: if (tick) begin
					ram_en_n <= 1'b0;
					state <= ST_RD2;
				end
				ST_RD2: if (tick) begin
					ram_oe_n <= 1'b0;
					state <= ST_RD3;
				end
				ST_RD3: if (tick) begin
					rdata <= bus_in;
					ram_oe_n <= 1'b1;
					ram_en_n <= 1'b1;
					finish <= 1'b1;
					state <= ST_IDLE;
				end

				// SRAM write
				ST_WR1: if (tick) begin
					ram_en_n <= 1'b0;
					bus_out <= wdata;
					bus_oe <= 1'b1;
					state <= ST_WR2;
				end
				ST_WR2: if (tick) begin
					ram_we_n <= 1'b0;
					state <= ST_WR3;
				end
				ST_WR3: if (tick) begin
					ram_we_n <= 1'b1;
					ram_en_n <= 1'b1;
					bus_oe <= 1'b0;
					finish <= 1'b1;
					state <= ST_IDLE;
				end

				// Read from the receive queue in two ticks
				ST_QPOP: if (tick) begin
					if (!pop_phase) begin
						rdata <= empty ? '0 : {{(`DATA_W-8){1'b0}}, front_data};
						pop_phase <= 1'b1;
					end else begin
						pop <= !empty;
						pop_phase <= 1'b0;
						finish <= 1'b1;
						state <= ST_IDLE;
					end
				end

				ST_STAT: if (tick) begin
					rdata <= {{(`DATA_W-2){1'b0}}, tbre && tsre, !empty};
					finish <= 1'b1;
					state <= ST_IDLE;
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- common/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// Bus widths
`define ADDR_W          18
`define DATA_W          16
`define TAG_W           8

// UART register map
`define UART_DATA_ADDR  18'h0BF00
`define UART_STAT_ADDR  18'h0BF01

// Receive queue depth is 2**QUEUE_AW
`define QUEUE_AW        3

// Core clocks per bus tick
`define TICK_DIV        4
// Ticks spent waiting on tbre or tsre before the write is retried
`define TX_WAIT_MAX     255

`endif

//--- common/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// Decoded memory stage operation
	typedef enum logic [2:0] {
		OP_NONE,
		OP_RAM_RD,
		OP_RAM_WR,
		OP_UART_RD,
		OP_UART_WR,
		OP_UART_STAT
	} mem_op_t;

	// Bus controller FSM
	typedef enum logic [4:0] {
		ST_IDLE,
		ST_RX1, ST_RX2, ST_RX3,
		ST_TX1, ST_TX2, ST_TX3, ST_TX4,
		ST_RD1, ST_RD2, ST_RD3,
		ST_WR1, ST_WR2, ST_WR3,
		ST_QPOP,
		ST_STAT
	} bus_state_t;

endpackage

`default_nettype wire

//--- rtl/mem_bus_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module mem_bus_top import bus_pkg::*; (
	input  wire                clk,
	input  wire                rst,
	// Memory stage request
	input  wire                req_valid,
	input  wire  [`TAG_W-1:0]  req_tag,
	input  wire                req_rd,
	input  wire                req_wr,
	input  wire  [`ADDR_W-1:0] req_addr,
	input  wire  [`DATA_W-1:0] req_wdata,
	output wire                done,
	output wire  [`DATA_W-1:0] rdata,
	// SRAM strobes
	output wire  [`ADDR_W-1:0] ram_addr,
	output wire                ram_en_n,
	output wire                ram_oe_n,
	output wire                ram_we_n,
	// Shared data bus, split for simulation
	output wire  [`DATA_W-1:0] bus_out,
	output wire                bus_oe,
	input  wire  [`DATA_W-1:0] bus_in,
	// UART chip
	output wire                uart_rdn,
	output wire                uart_wrn,
	input  wire                data_ready,
	input  wire                tbre,
	input  wire                tsre
);

	wire                start;
	wire                finish;
	mem_op_t            op;
	wire  [`ADDR_W-1:0] addr;
	wire  [`DATA_W-1:0] wdata;
	wire                push;
	wire  [7:0]         push_data;
	wire                pop;
	wire  [7:0]         front_data;
	wire                empty;
	wire                full;

	mem_request u_mem_request (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_rd    (req_rd),
		.req_wr    (req_wr),
		.req_tag   (req_tag),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.finish    (finish),
		.start     (start),
		.op        (op),
		.addr      (addr),
		.wdata     (wdata),
		.done      (done)
	);

	bus_ctrl u_bus_ctrl (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.op         (op),
		.addr       (addr),
		.wdata      (wdata),
		.front_data (front_data),
		.empty      (empty),
		.full       (full),
		.bus_in     (bus_in),
		.data_ready (data_ready),
		.tbre       (tbre),
		.tsre       (tsre),
		.finish     (finish),
		.rdata      (rdata),
		.push       (push),
		.push_data  (push_data),
		.pop        (pop),
		.ram_addr   (ram_addr),
		.ram_en_n   (ram_en_n),
		.ram_oe_n   (ram_oe_n),
		.ram_we_n   (ram_we_n),
		.bus_out    (bus_out),
		.bus_oe     (bus_oe),
		.uart_rdn   (uart_rdn),
		.uart_wrn   (uart_wrn)
	);

	rx_queue u_rx_queue (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_data  (push_data),
		.pop        (pop),
		.front_data (front_data),
		.empty      (empty),
		.full       (full)
	);

endmodule

`default_nettype wire

//--- rtl/mem_request.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module mem_request import bus_pkg::*; (
	input  wire                clk,
	input  wire                rst,
	input  wire                req_valid,
	input  wire                req_rd,
	input  wire                req_wr,
	input  wire  [`TAG_W-1:0]  req_tag,
	input  wire  [`ADDR_W-1:0] req_addr,
	input  wire  [`DATA_W-1:0] req_wdata,
	input  wire                finish,
	output logic               start,
	output mem_op_t            op,
	output logic [`ADDR_W-1:0] addr,
	output logic [`DATA_W-1:0] wdata,
	output wire                done
);

	logic [`TAG_W-1:0] tag_q;
	logic [`TAG_W-1:0] cur_tag;
	logic              tag_valid;
	logic              pending;
	logic              new_req;
	mem_op_t           dec_op;

	// A new tag is only looked at once the previous one is finished
	assign new_req = req_valid && !pending && (!tag_valid || req_tag != tag_q);
	assign done = tag_valid && !pending && (req_tag == tag_q);

	// Address and flag decode, write wins over read
	always_comb begin
		if (req_addr == `UART_DATA_ADDR) begin
			if (req_wr) dec_op = OP_UART_WR;
			else if (req_rd) dec_op = OP_UART_RD;
			else dec_op = OP_NONE;
		end else if (req_addr == `UART_STAT_ADDR) begin
			if (req_rd && !req_wr) dec_op = OP_UART_STAT;
			else dec_op = OP_NONE;
		end else begin
			if (req_wr) dec_op = OP_RAM_WR;
			else if (req_rd) dec_op = OP_RAM_RD;
			else dec_op = OP_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			tag_valid <= 1'b0;
			pending <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (new_req) begin
				if (dec_op == OP_NONE) begin
					// Nothing to run on the bus
					tag_valid <= 1'b1;
				end else begin
					pending <= 1'b1;
					start <= 1'b1;
				end
			end
			if (finish && pending) begin
				tag_valid <= 1'b1;
				pending <= 1'b0;
			end
		end
	end

	// Request payload held for the controller
	always_ff @(posedge clk) begin
		if (new_req) begin
			op <= dec_op;
			addr <= req_addr;
			wdata <= req_wdata;
			cur_tag <= req_tag;
			if (dec_op == OP_NONE)
				tag_q <= req_tag;
		end
		if (finish && pending)
			tag_q <= cur_tag;
	end

endmodule

`default_nettype wire

//--- rtl/rx_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module rx_queue (
	input  wire       clk,
	input  wire       rst,
	input  wire       push,
	input  wire [7:0] push_data,
	input  wire       pop,
	output wire [7:0] front_data,
	output wire       empty,
	output wire       full
);

	localparam int DEPTH = 1 << `QUEUE_AW;

	logic [7:0]         mem [DEPTH];
	// Extra top bit tells full from empty
	logic [`QUEUE_AW:0] front_ptr;
	logic [`QUEUE_AW:0] tail_ptr;

	assign empty = (front_ptr == tail_ptr);
	assign full = (front_ptr[`QUEUE_AW] != tail_ptr[`QUEUE_AW]) &&
		(front_ptr[`QUEUE_AW-1:0] == tail_ptr[`QUEUE_AW-1:0]);
	assign front_data = mem[front_ptr[`QUEUE_AW-1:0]];

	always_ff @(posedge clk) begin
		if (!rst) begin
			front_ptr <= '0;
			tail_ptr <= '0;
		end else begin
			if (push && !full)
				tail_ptr <= tail_ptr + 1'b1;
			if (pop && !empty)
				front_ptr <= front_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full)
			mem[tail_ptr[`QUEUE_AW-1:0]] <= push_data;
	end

endmodule

`default_nettype wire

//--- tests/board_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module board_model (
	input  wire                clk,
	input  wire                rst,
	input  wire  [`ADDR_W-1:0] ram_addr,
	input  wire                ram_en_n,
	input  wire                ram_oe_n,
	input  wire                ram_we_n,
	input  wire  [`DATA_W-1:0] bus_out,
	input  wire                bus_oe,
	output logic [`DATA_W-1:0] bus_in,
	input  wire                uart_rdn,
	input  wire                uart_wrn,
	output logic               data_ready,
	output wire                tbre,
	output wire                tsre,
	input  wire                hold_tbre,
	input  wire                inject,
	input  wire  [7:0]         inject_byte,
	output int                 rdn_count,
	output int                 wrn_count
);

	logic [`DATA_W-1:0] sram [logic [`ADDR_W-1:0]];
	logic [7:0]         rx_list [$];
	logic [7:0]         tx_log [$];
	logic [7:0]         tx_byte;
	logic               tx_busy;
	logic               prev_rdn;
	logic               prev_wrn;
	int                 tbre_cnt;
	int                 tsre_cnt;

	assign tbre = (tbre_cnt == 0) && !hold_tbre;
	assign tsre = !tx_busy;

	always @(posedge clk) begin
		if (!rst) begin
			tx_busy <= 1'b0;
			tbre_cnt <= 0;
			tsre_cnt <= 0;
			prev_rdn <= 1'b1;
			prev_wrn <= 1'b1;
			rdn_count <= 0;
			wrn_count <= 0;
			data_ready <= 1'b0;
			bus_in <= '0;
		end else begin
			prev_rdn <= uart_rdn;
			prev_wrn <= uart_wrn;
			if (!ram_en_n && !ram_we_n)
				sram[ram_addr] = bus_out;
			// Resolve the shared bus, whoever is asked to drive it
			if (!ram_en_n && !ram_oe_n)
				bus_in <= sram.exists(ram_addr) ? sram[ram_addr] : '0;
			else if (!uart_rdn)
				bus_in <= (rx_list.size() != 0) ? {8'h00, rx_list[0]} : '0;
			else
				bus_in <= bus_oe ? bus_out : '0;

			if (inject)
				rx_list.push_back(inject_byte);
			if (!uart_rdn && prev_rdn)
				rdn_count <= rdn_count + 1;
			// Next byte only after a full rdn strobe
			if (uart_rdn && !prev_rdn && rx_list.size() != 0)
				void'(rx_list.pop_front());
			data_ready <= (rx_list.size() != 0);

			if (!uart_wrn && prev_wrn) begin
				tx_byte <= bus_out[7:0];
				tx_busy <= 1'b1;
				tbre_cnt <= 6;
				tsre_cnt <= 12;
				wrn_count <= wrn_count + 1;
			end else begin
				if (tbre_cnt > 0)
					tbre_cnt <= tbre_cnt - 1;
				if (tbre && tsre_cnt > 0)
					tsre_cnt <= tsre_cnt - 1;
				// Transfer counts only once tsre is back
				if (tx_busy && tbre && tsre_cnt == 0) begin
					tx_log.push_back(tx_byte);
					tx_busy <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/mem_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bus_checker import bus_pkg::*; (
	input wire        clk,
	input wire        rst,
	input bus_state_t state,
	input wire        bus_oe,
	input wire        ram_en_n,
	input wire        ram_oe_n,
	input wire        ram_we_n,
	input wire        uart_rdn,
	input wire        push,
	input wire        full
);

	a_no_contention: assert property (@(posedge clk) disable iff (!rst)
		!(bus_oe && (!ram_oe_n || !uart_rdn)))
		else $error("bus driven while a chip is asked to drive it");

	a_we_needs_en: assert property (@(posedge clk) disable iff (!rst)
		!ram_we_n |-> !ram_en_n)
		else $error("ram_we_n low without ram_en_n");

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
		push |-> !full)
		else $error("push into a full receive queue");

	// SRAM idle between operations
	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst)
		state == ST_IDLE |-> ram_en_n && ram_oe_n && ram_we_n)
		else $error("SRAM strobe low in idle");

endmodule

bind bus_ctrl mem_bus_checker u_checker (
	.clk      (clk),
	.rst      (rst),
	.state    (state),
	.bus_oe   (bus_oe),
	.ram_en_n (ram_en_n),
	.ram_oe_n (ram_oe_n),
	.ram_we_n (ram_we_n),
	.uart_rdn (uart_rdn),
	.push     (push),
	.full     (full)
);

`default_nettype wire

//--- tests/tb_mem_bus.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module tb_mem_bus;

	localparam int PERIOD = 20;
	localparam int N_REQ = 150;
	localparam longint WATCHDOG_NS =
		longint'(N_REQ) * (2 * `TX_WAIT_MAX + 16) * `TICK_DIV * PERIOD * 2;

	logic               clk;
	logic               rst;
	logic               req_valid;
	logic [`TAG_W-1:0]  req_tag;
	logic               req_rd;
	logic               req_wr;
	logic [`ADDR_W-1:0] req_addr;
	logic [`DATA_W-1:0] req_wdata;
	wire                done;
	wire  [`DATA_W-1:0] rdata;
	wire  [`ADDR_W-1:0] ram_addr;
	wire                ram_en_n;
	wire                ram_oe_n;
	wire                ram_we_n;
	wire  [`DATA_W-1:0] bus_out;
	wire                bus_oe;
	wire  [`DATA_W-1:0] bus_in;
	wire                uart_rdn;
	wire                uart_wrn;
	wire                data_ready;
	wire                tbre;
	wire                tsre;
	logic               hold_tbre;
	logic               inject;
	logic [7:0]         inject_byte;
	int                 rdn_count;
	int                 wrn_count;

	integer             seed;
	int                 data_errors;
	int                 other_errors;
	int                 check_req;
	int                 check_seen;
	int                 strobe_cycles;
	logic [`TAG_W-1:0]  next_tag;
	logic [`DATA_W-1:0] exp_rdata;
	logic [`DATA_W-1:0] last_rdata;
	logic [`DATA_W-1:0] shadow_sram [logic [`ADDR_W-1:0]];
	logic [7:0]         shadow_rx [$];
	logic [7:0]         exp_tx [$];
	logic [`ADDR_W-1:0] addrs [40];

	mem_bus_top DUT (.*);

	board_model board (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

	// Count cycles with any strobe asserted
	always @(posedge clk) begin
		if (rst && (!ram_en_n || !ram_oe_n || !ram_we_n || !uart_rdn || !uart_wrn))
			strobe_cycles++;
	end

	always @(posedge clk) begin
		if (rst && done && check_seen != check_req) begin
			check_seen <= check_req;
			if (rdata !== exp_rdata) begin
				$display("[ERROR] %0t rdata expected %h got %h", $time, exp_rdata, rdata);
				data_errors++;
			end
		end
	end

	function automatic logic [`DATA_W-1:0] expected_read(input logic [`ADDR_W-1:0] a);
		if (a == `UART_DATA_ADDR)
			return (shadow_rx.size() != 0) ? {8'h00, shadow_rx[0]} : '0;
		else if (a == `UART_STAT_ADDR)
			return {14'h0000, tbre && tsre, shadow_rx.size() != 0};
		else
			return shadow_sram.exists(a) ? shadow_sram[a] : '0;
	endfunction

	task automatic run_req(input logic rd, input logic wr, input logic [`ADDR_W-1:0] a,
		input logic [`DATA_W-1:0] d);
		int waited;
		logic [`DATA_W-1:0] exp;
		exp = last_rdata;
		if (rd && !wr)
			exp = expected_read(a);
		@(posedge clk);
		req_valid <= 1'b1;
		req_tag <= next_tag;
		req_rd <= rd;
		req_wr <= wr;
		req_addr <= a;
		req_wdata <= d;
		if (!wr) begin
			exp_rdata <= exp;
			check_req <= check_req + 1;
			last_rdata = exp;
		end
		next_tag = next_tag + 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!done && waited < 20000);
		if (!done) begin
			$display("Timeout waiting for done on address %h", a);
			other_errors++;
		end
		if (wr && a == `UART_DATA_ADDR)
			exp_tx.push_back(d[7:0]);
		else if (wr && a != `UART_STAT_ADDR)
			shadow_sram[a] = d;
		else if (rd && a == `UART_DATA_ADDR && shadow_rx.size() != 0)
			void'(shadow_rx.pop_front());
	endtask

	task automatic inject_rx(input logic [7:0] b);
		@(posedge clk);
		inject <= 1'b1;
		inject_byte <= b;
		shadow_rx.push_back(b);
		@(posedge clk);
		inject <= 1'b0;
	endtask

	task automatic wait_rx(input int target);
		int waited;
		waited = 0;
		while (rdn_count < target && waited < 20000) begin
			@(posedge clk);
			waited++;
		end
		if (rdn_count < target) begin
			$display("Timeout waiting for the UART byte to be received");
			other_errors++;
		end
	endtask

	initial begin
		logic [31:0] tmp;
		logic [`ADDR_W-1:0] swap;
		int j;
		int r0;
		int w0;
		int s0;
		seed = 32'h0c850834;
		rst = 1'b0;
		req_valid = 1'b0;
		req_tag = '0;
		req_rd = 1'b0;
		req_wr = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		hold_tbre = 1'b0;
		inject = 1'b0;
		inject_byte = '0;
		next_tag = 8'h01;
		last_rdata = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b1;

		////////////////////
		// SRAM
		for (int i = 0; i < 40; i++) begin
			tmp = $random(seed);
			addrs[i] = {8'h00, tmp[9:0]};
			tmp = $random(seed);
			run_req(1'b0, 1'b1, addrs[i], tmp[15:0]);
		end
		for (int i = 39; i > 0; i--) begin
			j = $unsigned($random(seed)) % (i + 1);
			swap = addrs[i];
			addrs[i] = addrs[j];
			addrs[j] = swap;
		end
		for (int i = 0; i < 40; i++)
			run_req(1'b1, 1'b0, addrs[i], '0);

		////////////////////
		// UART transmit with the last write forced into a retry
		w0 = wrn_count;
		for (int i = 0; i < 4; i++) begin
			tmp = $random(seed);
			run_req(1'b0, 1'b1, `UART_DATA_ADDR, tmp[15:0]);
		end
		@(posedge clk);
		hold_tbre <= 1'b1;
		fork
			run_req(1'b0, 1'b1, `UART_DATA_ADDR, 16'h12a5);
			begin
				repeat ((`TX_WAIT_MAX + 40) * `TICK_DIV) @(posedge clk);
				hold_tbre <= 1'b0;
			end
		join
		if (wrn_count - w0 < 6) begin
			$display("No transmit retry seen while tbre was held low");
			other_errors++;
		end
		if (board.tx_log.size() != exp_tx.size()) begin
			$display("[ERROR] %0t tx_log size expected %0d got %0d", $time,
				exp_tx.size(), board.tx_log.size());
			other_errors++;
		end else begin
			for (int i = 0; i < exp_tx.size(); i++) begin
				if (board.tx_log[i] !== exp_tx[i]) begin
					$display("[ERROR] %0t tx_log[%0d] expected %h got %h", $time, i,
						exp_tx[i], board.tx_log[i]);
					other_errors++;
				end
			end
		end

		////////////////////
		// UART receive and status
		r0 = rdn_count;
		for (int i = 0; i < 3; i++) begin
			tmp = $random(seed);
			inject_rx(tmp[7:0]);
		end
		wait_rx(r0 + 3);
		run_req(1'b1, 1'b0, `UART_STAT_ADDR, '0);
		for (int i = 0; i < 4; i++)
			run_req(1'b1, 1'b0, `UART_DATA_ADDR, '0);
		run_req(1'b1, 1'b0, `UART_STAT_ADDR, '0);

		// Status with the transmitter busy
		@(posedge clk);
		hold_tbre <= 1'b1;
		@(posedge clk);
		run_req(1'b1, 1'b0, `UART_STAT_ADDR, '0);
		hold_tbre <= 1'b0;

		// Back-pressure with a full queue
		r0 = rdn_count;
		for (int i = 0; i < 10; i++) begin
			tmp = $random(seed);
			inject_rx(tmp[7:0]);
		end
		wait_rx(r0 + 8);
		repeat (200 * `TICK_DIV) @(posedge clk);
		if (rdn_count - r0 != 8) begin
			$display("[ERROR] %0t rdn_count expected %0d got %0d", $time, 8, rdn_count - r0);
			other_errors++;
		end
		for (int i = 0; i < 10; i++)
			run_req(1'b1, 1'b0, `UART_DATA_ADDR, '0);
		if (rdn_count - r0 != 10) begin
			$display("[ERROR] %0t rdn_count expected %0d got %0d", $time, 10, rdn_count - r0);
			other_errors++;
		end

		////////////////////
		// Empty request and a repeated tag
		run_req(1'b0, 1'b0, 18'h00005, '0);
		s0 = strobe_cycles;
		@(posedge clk);
		req_wr <= 1'b1;
		req_wdata <= 16'hbeef;
		repeat (50 * `TICK_DIV) @(posedge clk);
		if (strobe_cycles != s0) begin
			$display("Bus strobes moved for a tag that was already serviced");
			other_errors++;
		end
		if (!done) begin
			$display("done dropped for a tag that was already serviced");
			other_errors++;
		end

		$display("Errors: %0d data mismatches, %0d other failures", data_errors, other_errors);
		if (data_errors == 0 && other_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/bus_pkg.sv
rtl/mem_request.sv
bus_ctrl/bus_ctrl.sv
rtl/rx_queue.sv
rtl/mem_bus_top.sv
tests/board_model.sv
tests/mem_bus_checker.sv
tests/tb_mem_bus.sv
